/* include/tft_mem_macros.svh */
`ifndef TFT_MEM_MACROS_SVH
`define TFT_MEM_MACROS_SVH

// Power-up wait before the first init command
`define TFT_MEM_TINIT 200
// Auto-refresh interval
`define TFT_MEM_TREFC 100

// SDRAM command spacing, in clkSDRAM cycles
`define TFT_MEM_TRCD 2
`define TFT_MEM_CL 2
`define TFT_MEM_TRP 2
`define TFT_MEM_TRFC 7

// Cache index width, 256 one-word lines
`define TFT_MEM_IDX_W 8

// Light blue until the first fetch completes
`define TFT_MEM_RESET_RGB 24'h66ccff

`endif

/* design/tft_mem_pkg.sv */
package tft_mem_pkg;

	// SDRAM word address
	typedef struct packed {
		logic [1:0] bank;
		logic [12:0] row;
		logic [8:0] col;
	} mem_addr_t;

	typedef struct packed {
		logic [4:0] red;
		logic [5:0] green;
		logic [4:0] blue;
	} rgb565_t;

	typedef struct packed {
		logic [7:0] red;
		logic [7:0] green;
		logic [7:0] blue;
	} rgb888_t;

	// Valid is a level, held until the matching ready pulse
	typedef struct packed {
		logic valid;
		mem_addr_t addr;
	} mem_req_t;

	typedef struct packed {
		logic ready;
		rgb565_t data;
	} mem_rsp_t;

	typedef enum logic [2:0] {
		CMD_NOP,
		CMD_ACTIVE,
		CMD_READ,
		CMD_PRECHARGE,
		CMD_REFRESH,
		CMD_MODE
	} sdram_cmd_t;

	typedef struct packed {
		logic cke;
		logic cs_n;
		logic ras_n;
		logic cas_n;
		logic we_n;
		logic [1:0] ba;
		logic [12:0] addr;
		logic [1:0] dqm;
	} sdram_bus_t;

	typedef enum logic [2:0] {
		CTRL_POWERUP,
		CTRL_INIT_REF1,
		CTRL_INIT_REF2,
		CTRL_INIT_MODE,
		CTRL_IDLE,
		CTRL_RCD,
		CTRL_CAS,
		CTRL_SETTLE
	} ctrl_state_t;

	typedef enum logic [1:0] {
		CACHE_IDLE,
		CACHE_LOOKUP,
		CACHE_FILL,
		CACHE_RESPOND
	} cache_state_t;

endpackage

/* design/pix_fetch.sv */
`timescale 1ns/1ps
`include "tft_mem_macros.svh"

module pix_fetch import tft_mem_pkg::*; (
	input logic clkSDRAM,
	input logic n_reset_in,
	input logic pix_clk,
	input logic [8:0] pix_x,
	input logic [8:0] pix_y,
	input mem_rsp_t fetch_rsp,
	output mem_req_t fetch_req,
	output rgb888_t rgb,
	output logic fetch_busy
);

// Two synchronizer stages, then the previous value for edge detect
logic [2:0] pix_sync;
logic pix_fall;

logic req_valid;
mem_addr_t req_addr;

assign pix_fall = pix_sync[2] & ~pix_sync[1];

always_ff @(posedge clkSDRAM, negedge n_reset_in) begin
	if (!n_reset_in)
		pix_sync <= 3'b000;
	else
		pix_sync <= {pix_sync[1:0], pix_clk};
end

always_ff @(posedge clkSDRAM, negedge n_reset_in) begin
	if (!n_reset_in) begin
		req_valid <= 1'b0;
		rgb <= `TFT_MEM_RESET_RGB;
	end else if (req_valid) begin
		if (fetch_rsp.ready) begin
			// RGB565 to RGB888, low bits zero
			rgb <= '{
				red: {fetch_rsp.data.red, 3'b000},
				green: {fetch_rsp.data.green, 2'b00},
				blue: {fetch_rsp.data.blue, 3'b000}
			};
			req_valid <= 1'b0;
		end
	end else if (pix_fall) begin
		req_valid <= 1'b1;
	end
end

// Coordinates captured with the fall, stable while the request is up
always_ff @(posedge clkSDRAM) begin
	if (pix_fall && !req_valid)
		req_addr <= {6'b000000, pix_y, pix_x};
end

assign fetch_req = '{valid: req_valid, addr: req_addr};
assign fetch_busy = req_valid;

endmodule

/* design/line_cache.sv */
`timescale 1ns/1ps
`include "tft_mem_macros.svh"

module line_cache import tft_mem_pkg::*; (
	input logic clkSDRAM,
	input logic n_reset_in,
	input mem_req_t fetch_req,
	input mem_rsp_t mem_rsp,
	output mem_rsp_t fetch_rsp,
	output mem_req_t mem_req,
	output logic cache_miss
);

localparam int IDX_W = `TFT_MEM_IDX_W;
localparam int TAG_W = 24 - IDX_W;
localparam int LINES = 1 << IDX_W;

cache_state_t state;

logic [23:0] req_bits;
logic [IDX_W-1:0] req_idx;
logic [TAG_W-1:0] req_tag;

// Tag and data store, one word per line
logic [TAG_W-1:0] tag_mem [LINES];
rgb565_t data_mem [LINES];
logic [LINES-1:0] line_valid;

logic [TAG_W-1:0] rd_tag;
rgb565_t rd_data;
logic rd_valid;
logic hit;
logic fill_done;

logic rsp_ready;
rgb565_t rsp_data;
logic fill_valid;
mem_addr_t fill_addr;

assign req_bits = fetch_req.addr;
assign req_idx = req_bits[IDX_W-1:0];
assign req_tag = req_bits[23:IDX_W];

assign hit = rd_valid && (rd_tag == req_tag);
assign fill_done = (state == CACHE_FILL) && mem_rsp.ready;

// Array read is registered, so lookup takes one cycle
always_ff @(posedge clkSDRAM) begin
	if (state == CACHE_IDLE) begin
		rd_tag <= tag_mem[req_idx];
		rd_data <= data_mem[req_idx];
		rd_valid <= line_valid[req_idx];
	end
	if (fill_done) begin
		tag_mem[req_idx] <= req_tag;
		data_mem[req_idx] <= mem_rsp.data;
	end
end

always_ff @(posedge clkSDRAM) begin
	if (state == CACHE_LOOKUP) begin
		rsp_data <= rd_data;
		fill_addr <= fetch_req.addr;
	end else if (fill_done) begin
		rsp_data <= mem_rsp.data;
	end
end

always_ff @(posedge clkSDRAM, negedge n_reset_in) begin
	if (!n_reset_in) begin
		state <= CACHE_IDLE;
		line_valid <= '0;
		rsp_ready <= 1'b0;
		fill_valid <= 1'b0;
		cache_miss <= 1'b0;
	end else begin
		rsp_ready <= 1'b0;
		case (state)
		CACHE_IDLE: begin
			if (fetch_req.valid)
				state <= CACHE_LOOKUP;
		end
		CACHE_LOOKUP: begin
			if (hit) begin
				rsp_ready <= 1'b1;
				state <= CACHE_RESPOND;
			end else begin
				fill_valid <= 1'b1;
				cache_miss <= 1'b1;
				state <= CACHE_FILL;
			end
		end
		CACHE_FILL: begin
			if (mem_rsp.ready) begin
				fill_valid <= 1'b0;
				cache_miss <= 1'b0;
				line_valid[req_idx] <= 1'b1;
				rsp_ready <= 1'b1;
				state <= CACHE_RESPOND;
			end
		end
		// Gives the requester a cycle to drop valid
		CACHE_RESPOND: state <= CACHE_IDLE;
		default: state <= CACHE_IDLE;
		endcase
	end
end

assign fetch_rsp = '{ready: rsp_ready, data: rsp_data};
assign mem_req = '{valid: fill_valid, addr: fill_addr};

endmodule

/* design/sdram_ctrl.sv */
`timescale 1ns/1ps
`include "tft_mem_macros.svh"

module sdram_ctrl import tft_mem_pkg::*; (
	input logic clkSDRAM,
	input logic n_reset_in,
	input mem_req_t mem_req,
	input logic [15:0] dq_in,
	output mem_rsp_t mem_rsp,
	output sdram_bus_t sdram_bus,
	output logic [15:0] dq_out,
	output logic dq_oe
);

localparam int WAIT_W = $clog2(`TFT_MEM_TINIT + 1);
localparam int REF_W = $clog2(`TFT_MEM_TREFC + 1);

// Burst length 1, sequential, CAS latency from the macro
localparam logic [12:0] MODE_WORD = {6'b000000, 3'(`TFT_MEM_CL), 1'b0, 3'b000};
// A10 high selects all banks
localparam logic [12:0] PRE_ALL = 13'h0400;

ctrl_state_t state;
logic [WAIT_W-1:0] wait_cnt;
logic [REF_W-1:0] ref_cnt;
logic wait_done;
logic ref_due;

sdram_cmd_t cmd;
logic cke;
logic [1:0] ba;
logic [12:0] addr;

logic rsp_ready;
rgb565_t rsp_data;

// {cs_n, ras_n, cas_n, we_n}
function automatic logic [3:0] cmd_pins(input sdram_cmd_t c);
	case (c)
	CMD_ACTIVE: return 4'b0011;
	CMD_READ: return 4'b0101;
	CMD_PRECHARGE: return 4'b0010;
	CMD_REFRESH: return 4'b0001;
	CMD_MODE: return 4'b0000;
	default: return 4'b0111;
	endcase
endfunction

assign wait_done = (wait_cnt == '0);
assign ref_due = (ref_cnt == '0);

always_ff @(posedge clkSDRAM, negedge n_reset_in) begin
	if (!n_reset_in) begin
		state <= CTRL_POWERUP;
		wait_cnt <= WAIT_W'(`TFT_MEM_TINIT);
		ref_cnt <= REF_W'(`TFT_MEM_TREFC);
		cmd <= CMD_NOP;
		cke <= 1'b0;
		ba <= 2'b00;
		addr <= '0;
		rsp_ready <= 1'b0;
	end else begin
		// Clock enabled from the start of the power-up wait
		cke <= 1'b1;
		cmd <= CMD_NOP;
		rsp_ready <= 1'b0;
		if (!wait_done)
			wait_cnt <= wait_cnt - 1'b1;
		if (!ref_due)
			ref_cnt <= ref_cnt - 1'b1;

		case (state)
		CTRL_POWERUP: begin
			if (wait_done) begin
				cmd <= CMD_PRECHARGE;
				addr <= PRE_ALL;
				wait_cnt <= WAIT_W'(`TFT_MEM_TRP);
				state <= CTRL_INIT_REF1;
			end
		end
		CTRL_INIT_REF1, CTRL_INIT_REF2: begin
			if (wait_done) begin
				cmd <= CMD_REFRESH;
				ref_cnt <= REF_W'(`TFT_MEM_TREFC);
				wait_cnt <= WAIT_W'(`TFT_MEM_TRFC);
				state <= (state == CTRL_INIT_REF1) ? CTRL_INIT_REF2 : CTRL_INIT_MODE;
			end
		end
		CTRL_INIT_MODE: begin
			if (wait_done) begin
				cmd <= CMD_MODE;
				ba <= 2'b00;
				addr <= MODE_WORD;
				wait_cnt <= WAIT_W'(`TFT_MEM_TRP);
				state <= CTRL_SETTLE;
			end
		end
		CTRL_IDLE: begin
			// Refresh wins over a waiting read
			if (ref_due) begin
				cmd <= CMD_REFRESH;
				ref_cnt <= REF_W'(`TFT_MEM_TREFC);
				wait_cnt <= WAIT_W'(`TFT_MEM_TRFC);
				state <= CTRL_SETTLE;
			end else if (mem_req.valid) begin
				cmd <= CMD_ACTIVE;
				ba <= mem_req.addr.bank;
				addr <= mem_req.addr.row;
				wait_cnt <= WAIT_W'(`TFT_MEM_TRCD);
				state <= CTRL_RCD;
			end
		end
		CTRL_RCD: begin
			if (wait_done) begin
				cmd <= CMD_READ;
				addr <= {4'b0000, mem_req.addr.col};
				wait_cnt <= WAIT_W'(`TFT_MEM_CL);
				state <= CTRL_CAS;
			end
		end
		CTRL_CAS: begin
			// Data valid CL cycles after the READ is sampled
			if (wait_done) begin
				rsp_ready <= 1'b1;
				cmd <= CMD_PRECHARGE;
				addr <= PRE_ALL;
				wait_cnt <= WAIT_W'(`TFT_MEM_TRP);
				state <= CTRL_SETTLE;
			end
		end
		CTRL_SETTLE: begin
			if (wait_done)
				state <= CTRL_IDLE;
		end
		default: state <= CTRL_IDLE;
		endcase
	end
end

always_ff @(posedge clkSDRAM) begin
	if (state == CTRL_CAS && wait_done)
		rsp_data <= dq_in;
end

always_comb begin
	sdram_bus.cke = cke;
	{sdram_bus.cs_n, sdram_bus.ras_n, sdram_bus.cas_n, sdram_bus.we_n} = cmd_pins(cmd);
	sdram_bus.ba = ba;
	sdram_bus.addr = addr;
	sdram_bus.dqm = 2'b00;
end

assign mem_rsp = '{ready: rsp_ready, data: rsp_data};

// Read-only path, data bus never driven
assign dq_out = 16'h0000;
assign dq_oe = 1'b0;

endmodule

/* design/tft_mem_top.sv */
`timescale 1ns/1ps

module tft_mem_top import tft_mem_pkg::*; (
	input logic clkSDRAM,
	input logic n_reset_in,
	input logic pix_clk,
	input logic [8:0] pix_x,
	input logic [8:0] pix_y,
	input logic [15:0] dq_in,
	output rgb888_t rgb,
	output logic fetch_busy,
	output logic cache_miss,
	output sdram_bus_t sdram_bus,
	output logic [15:0] dq_out,
	output logic dq_oe
);

// Pixel fetch to cache
mem_req_t fetch_req;
mem_rsp_t fetch_rsp;

// Cache to SDRAM controller
mem_req_t mem_req;
mem_rsp_t mem_rsp;

pix_fetch u_fetch (
	.clkSDRAM(clkSDRAM),
	.n_reset_in(n_reset_in),
	.pix_clk(pix_clk),
	.pix_x(pix_x),
	.pix_y(pix_y),
	.fetch_rsp(fetch_rsp),
	.fetch_req(fetch_req),
	.rgb(rgb),
	.fetch_busy(fetch_busy)
);

line_cache u_cache (
	.clkSDRAM(clkSDRAM),
	.n_reset_in(n_reset_in),
	.fetch_req(fetch_req),
	.mem_rsp(mem_rsp),
	.fetch_rsp(fetch_rsp),
	.mem_req(mem_req),
	.cache_miss(cache_miss)
);

sdram_ctrl u_ctrl (
	.clkSDRAM(clkSDRAM),
	.n_reset_in(n_reset_in),
	.mem_req(mem_req),
	.dq_in(dq_in),
	.mem_rsp(mem_rsp),
	.sdram_bus(sdram_bus),
	.dq_out(dq_out),
	.dq_oe(dq_oe)
);

endmodule

/* tb/sdram_model.sv */
`timescale 1ns/1ps
`include "tft_mem_macros.svh"

module sdram_model import tft_mem_pkg::*; (
	input logic clkSDRAM,
	input logic n_reset_in,
	input sdram_bus_t sdram_bus,
	input logic [15:0] dq_out,
	input logic dq_oe,
	output logic [15:0] dq_in,
	output logic init_seen,
	output logic violation
);

localparam int CL = `TFT_MEM_CL;
localparam int REF_LIMIT = `TFT_MEM_TREFC + 20;

// {cs_n, ras_n, cas_n, we_n} from the SDRAM truth table
localparam logic [3:0] PIN_ACTIVE = 4'b0011;
localparam logic [3:0] PIN_READ = 4'b0101;
localparam logic [3:0] PIN_PRECHARGE = 4'b0010;
localparam logic [3:0] PIN_REFRESH = 4'b0001;
localparam logic [3:0] PIN_MODE = 4'b0000;

logic [3:0] pins;
logic [12:0] open_row [4];
logic [3:0] row_open;
logic mode_set;
logic pre_seen;
int init_refs;
logic ref_started;
int since_ref;
logic [23:0] rd_addr;
logic [15:0] pipe_data [CL];

assign pins = {sdram_bus.cs_n, sdram_bus.ras_n, sdram_bus.cas_n, sdram_bus.we_n};
assign rd_addr = {sdram_bus.ba, open_row[sdram_bus.ba], sdram_bus.addr[8:0]};

always_ff @(posedge clkSDRAM, negedge n_reset_in) begin
	if (!n_reset_in) begin
		row_open <= '0;
		mode_set <= 1'b0;
		pre_seen <= 1'b0;
		init_refs <= 0;
		init_seen <= 1'b0;
		ref_started <= 1'b0;
		since_ref <= 0;
		violation <= 1'b0;
	end else begin
		if (ref_started)
			since_ref <= since_ref + 1;
		if (sdram_bus.cke) begin
			case (pins)
			PIN_ACTIVE: begin
				row_open[sdram_bus.ba] <= 1'b1;
				open_row[sdram_bus.ba] <= sdram_bus.addr;
			end
			PIN_READ: begin
				if (!mode_set) begin
					$display("SDRAM model: READ issued before the mode register was set");
					violation <= 1'b1;
				end
				if (!row_open[sdram_bus.ba]) begin
					$display("SDRAM model: READ issued to bank %0d with no open row",
						sdram_bus.ba);
					violation <= 1'b1;
				end
			end
			PIN_PRECHARGE: begin
				pre_seen <= 1'b1;
				// A10 closes every bank
				if (sdram_bus.addr[10])
					row_open <= '0;
				else
					row_open[sdram_bus.ba] <= 1'b0;
			end
			PIN_REFRESH: begin
				ref_started <= 1'b1;
				since_ref <= 0;
				if (!mode_set)
					init_refs <= init_refs + 1;
			end
			PIN_MODE: begin
				mode_set <= 1'b1;
				if (pre_seen && init_refs >= 2)
					init_seen <= 1'b1;
			end
			default: ;
			endcase
		end
		if (ref_started && since_ref > REF_LIMIT && !violation) begin
			$display("SDRAM model: more than %0d cycles without a refresh", REF_LIMIT);
			violation <= 1'b1;
		end
		// No writes, so the outgoing data lines stay quiet
		if ((dq_oe || dq_out != 16'h0000) && !violation) begin
			$display("SDRAM model: controller drove the data bus, oe %0b value %04h",
				dq_oe, dq_out);
			violation <= 1'b1;
		end
	end
end

// Read data appears CL cycles after the READ edge
always_ff @(posedge clkSDRAM) begin
	if (sdram_bus.cke && pins == PIN_READ)
		pipe_data[0] <= rd_addr[15:0] ^ 16'hA5C3;
	else
		pipe_data[0] <= 16'h0000;
	for (int i = 1; i < CL; i++)
		pipe_data[i] <= pipe_data[i-1];
end

assign dq_in = pipe_data[CL-1];

endmodule

/* tb/tft_mem_asserts.sv */
`timescale 1ns/1ps
`include "tft_mem_macros.svh"

module tft_mem_asserts import tft_mem_pkg::*; (
	input logic clkSDRAM,
	input logic n_reset_in,
	input sdram_bus_t sdram_bus,
	input mem_rsp_t mem_rsp
);

logic [3:0] pins;
logic is_pre;
logic is_nop;
// Cycles left in the precharge window
int unsigned pre_gap;

assign pins = {sdram_bus.cs_n, sdram_bus.ras_n, sdram_bus.cas_n, sdram_bus.we_n};
assign is_pre = sdram_bus.cke && (pins == 4'b0010);
assign is_nop = sdram_bus.cs_n || (pins[2:0] == 3'b111);

always_ff @(posedge clkSDRAM, negedge n_reset_in) begin
	if (!n_reset_in)
		pre_gap <= 0;
	else if (is_pre)
		pre_gap <= `TFT_MEM_TRP;
	else if (pre_gap != 0)
		pre_gap <= pre_gap - 1;
end

// Checked one edge later, after the reset branch has run
cke_low_in_reset: assert property (@(posedge clkSDRAM) !n_reset_in |=> !sdram_bus.cke)
	else $error("cke high while reset is asserted");

nop_after_precharge: assert property (@(posedge clkSDRAM) disable iff (!n_reset_in)
	(pre_gap != 0) |-> is_nop)
	else $error("Command issued inside the precharge wait");

ready_single_cycle: assert property (@(posedge clkSDRAM) disable iff (!n_reset_in)
	mem_rsp.ready |=> !mem_rsp.ready)
	else $error("Controller ready held longer than one cycle");

endmodule

bind sdram_ctrl tft_mem_asserts u_asserts (
	.clkSDRAM(clkSDRAM),
	.n_reset_in(n_reset_in),
	.sdram_bus(sdram_bus),
	.mem_rsp(mem_rsp)
);

/* tb/tft_mem_tb.sv */
`timescale 1ns/1ps
`include "tft_mem_macros.svh"

module tft_mem_tb import tft_mem_pkg::*; ();

localparam int N_DIRECTED = 8;
localparam int N_ENTRIES = 40;
localparam int WAIT_LIMIT = 1000;
// Two synchronizer flops plus the request register
localparam int FALL_TO_BUSY = 3;

typedef struct packed {
	logic [8:0] x;
	logic [8:0] y;
	logic [7:0] hold;
	logic glitch;
	logic exp_miss;
	rgb888_t exp_rgb;
} stim_t;

logic clkSDRAM;
logic n_reset_in;
logic pix_clk;
logic [8:0] pix_x;
logic [8:0] pix_y;
logic [15:0] dq_in;
rgb888_t rgb;
logic fetch_busy;
logic cache_miss;
sdram_bus_t sdram_bus;
logic [15:0] dq_out;
logic dq_oe;
logic model_init_seen;
logic model_violation;

stim_t stim_table [N_ENTRIES];
logic [15:0] mirror_tag [256];
logic mirror_valid [256];
integer seed;
int entry_idx;

tft_mem_top UUT (
	.clkSDRAM(clkSDRAM),
	.n_reset_in(n_reset_in),
	.pix_clk(pix_clk),
	.pix_x(pix_x),
	.pix_y(pix_y),
	.dq_in(dq_in),
	.rgb(rgb),
	.fetch_busy(fetch_busy),
	.cache_miss(cache_miss),
	.sdram_bus(sdram_bus),
	.dq_out(dq_out),
	.dq_oe(dq_oe)
);

sdram_model u_sdram (
	.clkSDRAM(clkSDRAM),
	.n_reset_in(n_reset_in),
	.sdram_bus(sdram_bus),
	.dq_out(dq_out),
	.dq_oe(dq_oe),
	.dq_in(dq_in),
	.init_seen(model_init_seen),
	.violation(model_violation)
);

initial begin
	clkSDRAM = 1'b0;
	forever #4 clkSDRAM = ~clkSDRAM;
end

task automatic fail_now(input string what);
	$display("%s", what);
	$display("Regression failed");
	$fatal(1, "Stopped at the first error");
endtask

task automatic check_rgb(input rgb888_t actual, input rgb888_t expected);
	if (actual !== expected)
		fail_now($sformatf("MISMATCH rgb: got %06h expected %06h (entry %0d)",
			actual, expected, entry_idx));
endtask

task automatic check_miss(input string name, input logic actual, input logic expected);
	if (actual !== expected)
		fail_now($sformatf("MISMATCH %s: got %0h expected %0h (entry %0d)",
			name, actual, expected, entry_idx));
endtask

// Word is the low address bits XOR A5C3, channels widened with zero low bits
function automatic rgb888_t expected_rgb(input logic [8:0] x, input logic [8:0] y);
	logic [23:0] addr;
	logic [15:0] word;
	rgb888_t c;
	addr = {6'b000000, y, x};
	word = addr[15:0] ^ 16'hA5C3;
	c.red = {word[15:11], 3'b000};
	c.green = {word[10:5], 2'b00};
	c.blue = {word[4:0], 3'b000};
	return c;
endfunction

function automatic stim_t make_entry(input int x, input int y, input int hold, input logic g);
	stim_t e;
	e = '0;
	e.x = 9'(x);
	e.y = 9'(y);
	e.hold = 8'(hold);
	e.glitch = g;
	return e;
endfunction

task automatic build_table();
	logic [31:0] r;
	// Same index 10, tags differ by x[8]
	stim_table[0] = make_entry(10, 20, 4, 1'b0);
	stim_table[1] = make_entry(10, 20, 5, 1'b0);
	stim_table[2] = make_entry(266, 20, 4, 1'b0);
	stim_table[3] = make_entry(10, 20, 6, 1'b0);
	stim_table[4] = make_entry(266, 20, 3, 1'b0);
	stim_table[5] = make_entry(266, 20, 8, 1'b0);
	stim_table[6] = make_entry(100, 50, 6, 1'b1);
	stim_table[7] = make_entry(100, 50, 4, 1'b0);
	// Small coordinate range so hits and conflicts both occur
	for (int i = N_DIRECTED; i < N_ENTRIES; i++) begin
		r = $random(seed);
		stim_table[i] = make_entry({r[24], 4'b0000, r[3:0]}, 40 + r[17:16], 3 + r[30:28], 1'b0);
	end
endtask

// Tag mirror walked in table order
task automatic fill_expected();
	logic [7:0] idx;
	logic [15:0] tag;
	for (int i = 0; i < 256; i++)
		mirror_valid[i] = 1'b0;
	for (int i = 0; i < N_ENTRIES; i++) begin
		idx = stim_table[i].x[7:0];
		tag = {6'b000000, stim_table[i].y, stim_table[i].x[8]};
		stim_table[i].exp_miss = !(mirror_valid[idx] && mirror_tag[idx] == tag);
		mirror_valid[idx] = 1'b1;
		mirror_tag[idx] = tag;
		stim_table[i].exp_rgb = expected_rgb(stim_table[i].x, stim_table[i].y);
	end
endtask

task automatic wait_busy_rise(output int cycles);
	cycles = 0;
	forever begin
		@(negedge clkSDRAM);
		if (fetch_busy === 1'b1)
			break;
		cycles++;
		if (cycles > WAIT_LIMIT)
			fail_now($sformatf("fetch_busy never rose for entry %0d", entry_idx));
	end
endtask

task automatic apply_entry(input stim_t e);
	int rise_cycles;
	int busy_cycles;
	logic saw_miss;
	@(posedge clkSDRAM);
	pix_x <= e.x;
	pix_y <= e.y;
	pix_clk <= 1'b0;
	wait_busy_rise(rise_cycles);
	if (rise_cycles != FALL_TO_BUSY)
		fail_now($sformatf("fetch_busy rose %0d cycles after the fall, expected %0d",
			rise_cycles, FALL_TO_BUSY));
	busy_cycles = 0;
	saw_miss = 1'b0;
	while (fetch_busy === 1'b1) begin
		saw_miss = saw_miss | cache_miss;
		@(posedge clkSDRAM);
		busy_cycles++;
		// Second fall with other coordinates while the fetch is running
		if (e.glitch && busy_cycles == 1) begin
			pix_clk <= 1'b1;
			pix_x <= e.x + 9'd1;
			pix_y <= e.y + 9'd1;
		end
		if (e.glitch && busy_cycles == 2)
			pix_clk <= 1'b0;
		if (busy_cycles == int'(e.hold))
			pix_clk <= 1'b1;
		if (busy_cycles > WAIT_LIMIT)
			fail_now($sformatf("fetch_busy stuck high for entry %0d", entry_idx));
		@(negedge clkSDRAM);
	end
	check_rgb(rgb, e.exp_rgb);
	check_miss("cache_miss", saw_miss, e.exp_miss);
	@(posedge clkSDRAM);
	pix_clk <= 1'b1;
	if (e.glitch) begin
		for (int i = 0; i < 12; i++) begin
			@(negedge clkSDRAM);
			if (fetch_busy !== 1'b0)
				fail_now("A pixel-clock fall during a busy fetch started a second fetch");
		end
		check_rgb(rgb, e.exp_rgb);
	end
endtask

always @(negedge clkSDRAM) begin
	if (model_violation === 1'b1)
		fail_now("SDRAM model flagged a protocol violation");
end

initial begin
	n_reset_in = 1'b0;
	pix_clk = 1'b1;
	pix_x = 9'd0;
	pix_y = 9'd0;
	seed = 32'h31d6;
	entry_idx = -1;
	build_table();
	fill_expected();

	repeat (10) @(posedge clkSDRAM);
	n_reset_in <= 1'b1;
	@(negedge clkSDRAM);
	check_rgb(rgb, `TFT_MEM_RESET_RGB);
	check_miss("fetch_busy", fetch_busy, 1'b0);
	check_miss("cache_miss", cache_miss, 1'b0);
	// Let the synchronizer fill with the idle high level
	repeat (5) @(posedge clkSDRAM);

	for (int i = 0; i < N_ENTRIES; i++) begin
		entry_idx = i;
		apply_entry(stim_table[i]);
		if (i == 0 && model_init_seen !== 1'b1)
			fail_now("First pixel completed before the SDRAM init sequence was seen");
		repeat (2) @(posedge clkSDRAM);
	end

	repeat (20) @(posedge clkSDRAM);
	@(negedge clkSDRAM);
	if (model_violation === 1'b1) begin
		fail_now("SDRAM model flagged a protocol violation at the end of the run");
	end else begin
		$display("Regression passed");
		$finish;
	end
end

endmodule

/* list.f */
+incdir+include
design/tft_mem_pkg.sv
design/pix_fetch.sv
design/line_cache.sv
design/sdram_ctrl.sv
design/tft_mem_top.sv
tb/sdram_model.sv
tb/tft_mem_asserts.sv
tb/tft_mem_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the testbench with Verilator, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module tft_mem_tb -f list.f -o tft_mem_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/tft_mem_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Regression passed" "$LOG"; then
	exit 0
fi
echo "Pass line not found in $LOG"
exit 1
